// ==== Bender.yml ====
package:
  name: saturn_glue

sources:
  - include_dirs:
      - design
    files:
      - design/saturn_pkg.sv
      - design/saturnClockEnables.sv
      - design/mainBusRouter.sv
      - design/busDebugMonitor.sv
      - design/saturnGlue.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/saturnGlue_props.sv
      - verif/saturnGlue_tb.sv

// ==== design/busDebugMonitor.sv ====
`default_nettype none

`include "saturn_settings.svh"

module busDebugMonitor (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 cpuCeR,
	input  logic                 cdCeR,
	input  saturn_pkg::mainAddrT cAddr,
	input  saturn_pkg::dqmT      cDqmN,
	input  logic                 cRdN,
	input  logic                 cCs3N,
	input  saturn_pkg::cdAddrT   cdAddr,
	input  logic                 cdCs1N,
	input  logic                 cdWrlN,
	input  logic                 cdWrhN,
	output saturn_pkg::dbgCntT   dbgWaitCnt,
	output saturn_pkg::dbgCntT   dbgCdCnt,
	output logic                 dbgHook
);
	import saturn_pkg::*;

	localparam mainAddrT hookAddr = `HOOK_ADDR;
	localparam cdAddrT cdWatchAddr = `CD_WATCH_ADDR;

	logic busIdle;
	logic cdWr;
	logic cdWrOld;

	assign busIdle = cRdN & (&cDqmN);
	assign cdWr = ~cdWrlN | ~cdWrhN;

	// Rising phases spent in the current bus cycle
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgWaitCnt <= '0;
		end else if (cpuCeR) begin
			dbgWaitCnt <= busIdle ? '0 : dbgWaitCnt + 1'b1;
		end
	end

	// Sticky once the watched fetch is seen
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dbgHook <= 1'b0;
		end else if (cpuCeR && cAddr == hookAddr && !cRdN && !cCs3N) begin
			dbgHook <= 1'b1;
		end
	end

	// Count leading edges of CD buffer writes to the watched word
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdWrOld <= 1'b0;
			dbgCdCnt <= '0;
		end else if (cdCeR) begin
			cdWrOld <= cdWr;
			if (cdWr && !cdWrOld && !cdCs1N && cdAddr == cdWatchAddr) begin
				dbgCdCnt <= dbgCdCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/mainBusRouter.sv ====
`default_nettype none

module mainBusRouter (
	// CPU bus and memory selects
	input  saturn_pkg::mainAddrT cAddr,
	input  saturn_pkg::wordT     cWrData,
	input  saturn_pkg::dqmT      cDqmN,
	input  logic                 cRdN,
	input  logic                 cCs3N,
	input  logic                 dramCeN,
	input  logic                 romCeN,
	input  logic                 smpcCeN,

	// Read sources
	input  saturn_pkg::wordT     memDi,
	input  saturn_pkg::wordT     scuDo,
	input  saturn_pkg::byteT     smpcDo,

	// Waits
	input  logic                 memWaitN,
	input  logic                 cWaitN,

	// B-bus
	input  logic                 bCs1N,
	input  logic                 bCs2N,
	input  logic                 bCssN,
	input  saturn_pkg::halfT     vdp1Do,
	input  saturn_pkg::halfT     vdp2Do,
	input  saturn_pkg::halfT     scspDo,

	// Arbitration
	input  logic                 sshBreqN,
	input  logic                 scuBreqN,
	input  logic                 mshBgrN,

	output saturn_pkg::wordT     cRdData,
	output logic                 mshWaitN,
	output logic                 sshWaitN,
	output saturn_pkg::halfT     bRdData,

	output logic                 mshBrlsN,
	output logic                 sshBackN,
	output logic                 scuBackN,

	output saturn_pkg::mainAddrT memA,
	output saturn_pkg::wordT     memDo,
	output saturn_pkg::dqmT      memDqmN,
	output logic                 memRdN,
	output logic                 romCsN,
	output logic                 ramLCsN,
	output logic                 ramHCsN
);
	import saturn_pkg::*;

	logic memSel;
	wordT smpcWord;

	// Any external memory region selected
	assign memSel = ~cCs3N | ~dramCeN | ~romCeN;

	// System manager is byte wide, replicated on every lane
	assign smpcWord = {4{smpcDo}};

	assign cRdData = memSel   ? memDi :
	                 !smpcCeN ? smpcWord :
	                 scuDo;

	// Memory wait only matters while memory is selected
	assign mshWaitN = cWaitN & (memWaitN | ~memSel);
	assign sshWaitN = cWaitN & (memWaitN | ~memSel);

	assign bRdData = !bCs1N ? vdp1Do :
	                 !bCs2N ? vdp2Do :
	                 !bCssN ? scspDo :
	                 '0;

	// Master releases the bus when either requester asks
	assign mshBrlsN = sshBreqN & scuBreqN;
	assign sshBackN = mshBgrN;
	assign scuBackN = mshBgrN | ~sshBreqN;

	assign memA    = cAddr;
	assign memDo   = cWrData;
	assign memDqmN = cDqmN;
	assign memRdN  = cRdN;
	assign romCsN  = romCeN;
	assign ramLCsN = dramCeN;
	assign ramHCsN = cCs3N;

endmodule

`default_nettype wire

// ==== design/saturnClockEnables.sv ====
`default_nettype none

`include "saturn_settings.svh"

module saturnClockEnables (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic pauseEn,
	input  logic cdCe,
	output logic cpuCeR,
	output logic cpuCeF,
	output logic cdCeR,
	output logic cdCeF,
	output logic smpcCe,
	output logic mresN
);
	import saturn_pkg::*;

	localparam smpcCntT smpcLast = smpcCntT'(`SMPC_DIV - 1);

	logic mclk;
	logic cdClk;
	smpcCntT smpcCnt;

	// Main CPU half-rate toggle, frozen by pause
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pauseEn) begin
			mclk <= ~mclk;
		end
	end

	assign cpuCeR = mclk & ~pauseEn;
	assign cpuCeF = ~mclk & ~pauseEn;

	// CD CPU half-rate toggle
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdClk <= 1'b0;
		end else if (cdCe) begin
			cdClk <= ~cdClk;
		end
	end

	assign cdCeR = cdClk & cdCe;
	assign cdCeF = ~cdClk & cdCe;

	// System manager tick, one per SMPC_DIV rising phases
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smpcCnt <= '0;
			smpcCe <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (cpuCeR) begin
				if (smpcCnt == smpcLast) begin
					smpcCnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					smpcCnt <= smpcCnt + 1'b1;
				end
			end
		end
	end

	// Master reset released after the first tick, then held
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcCe) begin
			mresN <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/saturnGlue.sv ====
`default_nettype none

module saturnGlue (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 pauseEn,
	input  logic                 cdCe,

	// Main CPU bus
	input  saturn_pkg::mainAddrT cAddr,
	input  saturn_pkg::wordT     cWrData,
	input  saturn_pkg::dqmT      cDqmN,
	input  logic                 cRdN,
	input  logic                 cCs3N,
	input  logic                 dramCeN,
	input  logic                 romCeN,
	input  logic                 smpcCeN,
	input  saturn_pkg::wordT     memDi,
	input  saturn_pkg::wordT     scuDo,
	input  saturn_pkg::byteT     smpcDo,
	input  logic                 memWaitN,
	input  logic                 cWaitN,

	// B-bus
	input  logic                 bCs1N,
	input  logic                 bCs2N,
	input  logic                 bCssN,
	input  saturn_pkg::halfT     vdp1Do,
	input  saturn_pkg::halfT     vdp2Do,
	input  saturn_pkg::halfT     scspDo,

	// Bus arbitration
	input  logic                 sshBreqN,
	input  logic                 scuBreqN,
	input  logic                 mshBgrN,

	// CD buffer bus
	input  saturn_pkg::cdAddrT   cdAddr,
	input  logic                 cdCs1N,
	input  logic                 cdWrlN,
	input  logic                 cdWrhN,

	output logic                 cpuCeR,
	output logic                 cpuCeF,
	output logic                 cdCeR,
	output logic                 cdCeF,
	output logic                 smpcCe,
	output logic                 mresN,

	output saturn_pkg::wordT     cRdData,
	output logic                 mshWaitN,
	output logic                 sshWaitN,
	output saturn_pkg::halfT     bRdData,
	output logic                 mshBrlsN,
	output logic                 sshBackN,
	output logic                 scuBackN,

	output saturn_pkg::mainAddrT memA,
	output saturn_pkg::wordT     memDo,
	output saturn_pkg::dqmT      memDqmN,
	output logic                 memRdN,
	output logic                 romCsN,
	output logic                 ramLCsN,
	output logic                 ramHCsN,

	output saturn_pkg::dbgCntT   dbgWaitCnt,
	output saturn_pkg::dbgCntT   dbgCdCnt,
	output logic                 dbgHook
);

	saturnClockEnables u_clk (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.ce      (ce),
		.pauseEn (pauseEn),
		.cdCe    (cdCe),
		.cpuCeR  (cpuCeR),
		.cpuCeF  (cpuCeF),
		.cdCeR   (cdCeR),
		.cdCeF   (cdCeF),
		.smpcCe  (smpcCe),
		.mresN   (mresN)
	);

	mainBusRouter u_bus (
		.cAddr    (cAddr),
		.cWrData  (cWrData),
		.cDqmN    (cDqmN),
		.cRdN     (cRdN),
		.cCs3N    (cCs3N),
		.dramCeN  (dramCeN),
		.romCeN   (romCeN),
		.smpcCeN  (smpcCeN),
		.memDi    (memDi),
		.scuDo    (scuDo),
		.smpcDo   (smpcDo),
		.memWaitN (memWaitN),
		.cWaitN   (cWaitN),
		.bCs1N    (bCs1N),
		.bCs2N    (bCs2N),
		.bCssN    (bCssN),
		.vdp1Do   (vdp1Do),
		.vdp2Do   (vdp2Do),
		.scspDo   (scspDo),
		.sshBreqN (sshBreqN),
		.scuBreqN (scuBreqN),
		.mshBgrN  (mshBgrN),
		.cRdData  (cRdData),
		.mshWaitN (mshWaitN),
		.sshWaitN (sshWaitN),
		.bRdData  (bRdData),
		.mshBrlsN (mshBrlsN),
		.sshBackN (sshBackN),
		.scuBackN (scuBackN),
		.memA     (memA),
		.memDo    (memDo),
		.memDqmN  (memDqmN),
		.memRdN   (memRdN),
		.romCsN   (romCsN),
		.ramLCsN  (ramLCsN),
		.ramHCsN  (ramHCsN)
	);

	// Monitors sample on the phase enables from u_clk
	busDebugMonitor u_dbg (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.cpuCeR     (cpuCeR),
		.cdCeR      (cdCeR),
		.cAddr      (cAddr),
		.cDqmN      (cDqmN),
		.cRdN       (cRdN),
		.cCs3N      (cCs3N),
		.cdAddr     (cdAddr),
		.cdCs1N     (cdCs1N),
		.cdWrlN     (cdWrlN),
		.cdWrhN     (cdWrhN),
		.dbgWaitCnt (dbgWaitCnt),
		.dbgCdCnt   (dbgCdCnt),
		.dbgHook    (dbgHook)
	);

endmodule

`default_nettype wire

// ==== design/saturn_pkg.sv ====
`default_nettype none

`include "saturn_settings.svh"

package saturn_pkg;

	// Main bus
	typedef logic [`MAIN_ADDR_W-1:0] mainAddrT;
	typedef logic [`WORD_W-1:0] wordT;
	typedef logic [`DQM_W-1:0] dqmT;

	// B-bus word
	typedef logic [`HALF_W-1:0] halfT;

	// System manager data
	typedef logic [`BYTE_W-1:0] byteT;

	// CD buffer word address
	typedef logic [`CD_ADDR_W-1:0] cdAddrT;

	// Debug monitor counter
	typedef logic [`DBG_CNT_W-1:0] dbgCntT;

	// Tick divider
	typedef logic [`SMPC_CNT_W-1:0] smpcCntT;

endpackage

`default_nettype wire

// ==== design/saturn_settings.svh ====
`ifndef SATURN_SETTINGS_SVH
`define SATURN_SETTINGS_SVH

// Main bus widths
`define MAIN_ADDR_W 25
`define WORD_W 32
`define DQM_W 4

// B-bus and system manager data
`define HALF_W 16
`define BYTE_W 8

// CD buffer word address
`define CD_ADDR_W 18

// Debug counters
`define DBG_CNT_W 8

// Rising phases per system-manager tick
`define SMPC_DIV 7
`define SMPC_CNT_W 3

// Fetch address that arms the hook
`define HOOK_ADDR 25'h0012B0

// CD buffer word counted by the monitor
`define CD_WATCH_ADDR 18'h3AC0C

`endif

// ==== files.f ====
+incdir+design
design/saturn_pkg.sv
design/saturnClockEnables.sv
design/mainBusRouter.sv
design/busDebugMonitor.sv
design/saturnGlue.sv
verif/saturnGlue_props.sv
verif/saturnGlue_tb.sv

// ==== verif/saturnGlue_props.sv ====
`default_nettype none

module saturnGlue_props (
	input logic CLK,
	input logic RST_N,
	input logic pauseEn,
	input logic cpuCeR,
	input logic cpuCeF,
	input logic smpcCe,
	input logic mresN
);
	int failCnt = 0;

	// Phase enables are exclusive
	assert property (@(posedge CLK) disable iff (!RST_N) !(cpuCeR && cpuCeF))
	else begin
		failCnt++;
		$error("cpuCeR and cpuCeF high in the same cycle");
	end

	// Tick lasts one cycle
	assert property (@(posedge CLK) disable iff (!RST_N) smpcCe |=> !smpcCe)
	else begin
		failCnt++;
		$error("smpcCe high for two cycles in a row");
	end

	assert property (@(posedge CLK) disable iff (!RST_N) mresN |=> mresN)
	else begin
		failCnt++;
		$error("mresN fell after its release");
	end

	// Pause holds both phases low
	assert property (@(posedge CLK) disable iff (!RST_N) pauseEn |-> !cpuCeR && !cpuCeF)
	else begin
		failCnt++;
		$error("Phase enable high during pause");
	end

endmodule

bind saturnClockEnables saturnGlue_props u_props (.*);

`default_nettype wire

// ==== verif/saturnGlue_tb.sv ====
`default_nettype none

`include "saturn_settings.svh"

module saturnGlue_tb;
	import saturn_pkg::*;

	localparam int waitLimit = 20;

	logic CLK;
	logic RST_N;
	logic ce;
	logic pauseEn;
	logic cdCe;
	mainAddrT cAddr;
	wordT cWrData;
	dqmT cDqmN;
	logic cRdN;
	logic cCs3N;
	logic dramCeN;
	logic romCeN;
	logic smpcCeN;
	wordT memDi;
	wordT scuDo;
	byteT smpcDo;
	logic memWaitN;
	logic cWaitN;
	logic bCs1N, bCs2N, bCssN;
	halfT vdp1Do, vdp2Do, scspDo;
	logic sshBreqN, scuBreqN, mshBgrN;
	cdAddrT cdAddr;
	logic cdCs1N, cdWrlN, cdWrhN;

	logic cpuCeR, cpuCeF, cdCeR, cdCeF, smpcCe, mresN;
	wordT cRdData;
	logic mshWaitN, sshWaitN;
	halfT bRdData;
	logic mshBrlsN, sshBackN, scuBackN;
	mainAddrT memA;
	wordT memDo;
	dqmT memDqmN;
	logic memRdN, romCsN, ramLCsN, ramHCsN;
	dbgCntT dbgWaitCnt, dbgCdCnt;
	logic dbgHook;

	int valueErrs;
	int timeoutErrs;
	int assertErrs;

	saturnGlue u_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic checkWord(input wordT got, input wordT exp, input string what);
		if (got !== exp) begin
			valueErrs++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkHalf(input halfT got, input halfT exp, input string what);
		if (got !== exp) begin
			valueErrs++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCnt(input dbgCntT got, input dbgCntT exp, input string what);
		if (got !== exp) begin
			valueErrs++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			valueErrs++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Let one rising phase (CPU or CD side) pass with the current inputs
	task automatic passPhase(input bit cdSide);
		int n;
		n = 0;
		#1;
		while (!(cdSide ? cdCeR : cpuCeR) && n < waitLimit) begin
			@(negedge CLK);
			#1;
			n++;
		end
		if (!(cdSide ? cdCeR : cpuCeR)) begin
			timeoutErrs++;
			$display("Timeout at %0t: no rising phase arrived, cdSide=%0d", $time, cdSide);
		end
		@(negedge CLK);
	endtask

	task automatic tickAndRelease();
		int rises;
		logic rise;
		logic expTick;
		logic tickSeen;
		rises = 0;
		tickSeen = 1'b0;
		ce = 1'b1;
		for (int i = 0; i < 6 * `SMPC_DIV; i++) begin
			#1;
			rise = cpuCeR;
			@(negedge CLK);
			if (rise) begin
				rises++;
			end
			expTick = rise && (rises % `SMPC_DIV == 0);
			checkBit(smpcCe, expTick, "smpcCe");
			checkBit(mresN, tickSeen, "mresN");
			tickSeen = tickSeen | expTick;
		end
	endtask

	task automatic phaseEnables();
		logic expR;
		logic heldR;
		expR = cpuCeR;
		for (int i = 0; i < 8; i++) begin
			@(negedge CLK);
			expR = ~expR;
			checkBit(cpuCeR, expR, "cpuCeR toggle");
			checkBit(cpuCeF, ~expR, "cpuCeF opposite");
		end
		heldR = expR;
		pauseEn = 1'b1;
		for (int i = 0; i < 6; i++) begin
			#1;
			checkBit(cpuCeR, 1'b0, "cpuCeR in pause");
			checkBit(cpuCeF, 1'b0, "cpuCeF in pause");
			@(negedge CLK);
		end
		pauseEn = 1'b0;
		cdCe = 1'b1;
		#1;
		checkBit(cpuCeR, heldR, "cpuCeR after pause");
		expR = cdCeR;
		for (int i = 0; i < 8; i++) begin
			@(negedge CLK);
			expR = ~expR;
			checkBit(cdCeR, expR, "cdCeR toggle");
			checkBit(cdCeF, ~expR, "cdCeF opposite");
		end
		cdCe = 1'b0;
		for (int i = 0; i < 4; i++) begin
			#1;
			checkBit(cdCeR | cdCeF, 1'b0, "CD phases without cdCe");
			@(negedge CLK);
		end
	endtask

	task automatic mainBusRouting();
		logic memSel;
		wordT expData;
		for (int i = 0; i < 64; i++) begin
			@(negedge CLK);
			{cCs3N, dramCeN, romCeN, smpcCeN, memWaitN, cWaitN} = 6'(i);
			memDi = $urandom;
			scuDo = $urandom;
			smpcDo = byteT'($urandom);
			cAddr = mainAddrT'($urandom);
			cWrData = $urandom;
			cDqmN = dqmT'($urandom);
			cRdN = 1'($urandom);
			#1;
			memSel = !cCs3N || !dramCeN || !romCeN;
			expData = memSel ? memDi : (!smpcCeN ? {smpcDo, smpcDo, smpcDo, smpcDo} : scuDo);
			checkWord(cRdData, expData, "cRdData");
			checkBit(mshWaitN, cWaitN && (memWaitN || !memSel), "mshWaitN");
			checkBit(sshWaitN, cWaitN && (memWaitN || !memSel), "sshWaitN");
			checkWord(wordT'(memA), wordT'(cAddr), "memA");
			checkWord(memDo, cWrData, "memDo");
			checkWord(wordT'(memDqmN), wordT'(cDqmN), "memDqmN");
			checkBit(memRdN, cRdN, "memRdN");
			checkBit(romCsN, romCeN, "romCsN");
			checkBit(ramLCsN, dramCeN, "ramLCsN");
			checkBit(ramHCsN, cCs3N, "ramHCsN");
		end
	endtask

	task automatic bBusArbitration();
		halfT expHalf;
		for (int i = 0; i < 8; i++) begin
			@(negedge CLK);
			{bCs1N, bCs2N, bCssN} = 3'(i);
			{sshBreqN, scuBreqN, mshBgrN} = 3'(i);
			vdp1Do = halfT'($urandom);
			vdp2Do = halfT'($urandom);
			scspDo = halfT'($urandom);
			#1;
			expHalf = !bCs1N ? vdp1Do : (!bCs2N ? vdp2Do : (!bCssN ? scspDo : '0));
			checkHalf(bRdData, expHalf, "bRdData");
			checkBit(mshBrlsN, sshBreqN && scuBreqN, "mshBrlsN");
			checkBit(sshBackN, mshBgrN, "sshBackN");
			checkBit(scuBackN, mshBgrN || !sshBreqN, "scuBackN");
		end
	endtask

	task automatic waitCounterHook();
		dbgCntT expCnt;
		logic rise;
		@(negedge CLK);
		{cCs3N, dramCeN, romCeN, smpcCeN, cRdN} = '1;
		cDqmN = '1;
		cAddr = `HOOK_ADDR ^ 25'd1;
		passPhase(1'b0);
		checkCnt(dbgWaitCnt, '0, "dbgWaitCnt idle");
		// Read one address off the hook
		cRdN = 1'b0;
		cCs3N = 1'b0;
		expCnt = '0;
		for (int i = 0; i < 10; i++) begin
			#1;
			rise = cpuCeR;
			@(negedge CLK);
			expCnt = expCnt + dbgCntT'(rise);
			checkCnt(dbgWaitCnt, expCnt, "dbgWaitCnt active");
		end
		checkBit(dbgHook, 1'b0, "dbgHook near address");
		cAddr = `HOOK_ADDR;
		cCs3N = 1'b1;
		passPhase(1'b0);
		checkBit(dbgHook, 1'b0, "dbgHook without cCs3N");
		cCs3N = 1'b0;
		cRdN = 1'b1;
		passPhase(1'b0);
		checkBit(dbgHook, 1'b0, "dbgHook without read");
		cRdN = 1'b0;
		passPhase(1'b0);
		checkBit(dbgHook, 1'b1, "dbgHook on fetch");
		cAddr = '0;
		cRdN = 1'b1;
		passPhase(1'b0);
		checkBit(dbgHook, 1'b1, "dbgHook sticky");
		checkCnt(dbgWaitCnt, '0, "dbgWaitCnt cleared");
	endtask

	task automatic cdWriteCounter();
		cdCe = 1'b1;
		cdCs1N = 1'b0;
		cdAddr = `CD_WATCH_ADDR ^ 18'd1;
		{cdWrlN, cdWrhN} = 2'b11;
		passPhase(1'b1);
		cdWrlN = 1'b0;
		passPhase(1'b1);
		cdWrlN = 1'b1;
		passPhase(1'b1);
		checkCnt(dbgCdCnt, '0, "dbgCdCnt other address");
		cdAddr = `CD_WATCH_ADDR;
		cdCs1N = 1'b1;
		cdWrhN = 1'b0;
		passPhase(1'b1);
		cdWrhN = 1'b1;
		passPhase(1'b1);
		checkCnt(dbgCdCnt, '0, "dbgCdCnt deselected");
		// Held strobe spans several CD phases
		cdCs1N = 1'b0;
		cdWrlN = 1'b0;
		repeat (4) passPhase(1'b1);
		checkCnt(dbgCdCnt, 8'd1, "dbgCdCnt held strobe");
		cdWrlN = 1'b1;
		passPhase(1'b1);
		repeat (2) begin
			cdWrhN = 1'b0;
			passPhase(1'b1);
			cdWrhN = 1'b1;
			passPhase(1'b1);
		end
		checkCnt(dbgCdCnt, 8'd3, "dbgCdCnt three pulses");
	endtask

	initial begin
		void'($urandom(32'h99da_4521));
		valueErrs = 0;
		timeoutErrs = 0;
		RST_N = 1'b0;
		{ce, pauseEn, cdCe} = '0;
		{cCs3N, dramCeN, romCeN, smpcCeN} = '1;
		{cRdN, memWaitN, cWaitN} = '1;
		{bCs1N, bCs2N, bCssN} = '1;
		{sshBreqN, scuBreqN, mshBgrN} = '1;
		{cdCs1N, cdWrlN, cdWrhN} = '1;
		cAddr = '0;
		cWrData = '0;
		cDqmN = '1;
		memDi = '0;
		scuDo = '0;
		smpcDo = '0;
		{vdp1Do, vdp2Do, scspDo} = '0;
		cdAddr = '0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		checkBit(smpcCe, 1'b0, "smpcCe after reset");
		checkBit(mresN, 1'b0, "mresN after reset");
		checkBit(cpuCeR, 1'b0, "cpuCeR after reset");
		checkCnt(dbgWaitCnt, '0, "dbgWaitCnt after reset");
		checkBit(dbgHook, 1'b0, "dbgHook after reset");
		checkCnt(dbgCdCnt, '0, "dbgCdCnt after reset");
		tickAndRelease();
		phaseEnables();
		mainBusRouting();
		bBusArbitration();
		waitCounterHook();
		cdWriteCounter();
		assertErrs = u_dut.u_clk.u_props.failCnt;
		$display("Errors: %0d value, %0d timeout, %0d assertion",
			valueErrs, timeoutErrs, assertErrs);
		if (valueErrs == 0 && timeoutErrs == 0 && assertErrs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
